/* aesDecrypt_cfg.svh */
`ifndef AES_DECRYPT_CFG_SVH
`define AES_DECRYPT_CFG_SVH

// ####################
// AES-128 round structure
`define AES_NUM_ROUNDS 10
`define AES_NUM_ROUND_KEYS (`AES_NUM_ROUNDS + 1)
`define AES_ROUND_W 4

`endif

/* aesTypesPkg.sv */
package aesTypesPkg;

	typedef logic [127:0] aesBlockT; // Byte 0 in bits 127:120
	typedef logic [31:0] aesWordT; // One key schedule word

	// Column-major state, byte index is 4*column + row
	typedef union packed {
		logic [0:15][7:0] bytes;
		logic [0:3][31:0] cols;
	} aesStateU;

	// ####################
	// GF(2^8) arithmetic, polynomial x^8 + x^4 + x^3 + x + 1

	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] acc;
		logic [7:0] p;
		acc = 8'h00;
		p = a;
		for (int i = 0; i < 8; i++)
		begin
			if (b[i])
				acc = acc ^ p;
			p = xtime(p);
		end
		return acc;
	endfunction

	// x^254 is the field inverse, and zero maps to zero
	function automatic logic [7:0] gfInv(input logic [7:0] b);
		logic [7:0] r;
		logic [7:0] p;
		r = 8'h01;
		p = b;
		for (int i = 0; i < 7; i++)
		begin
			p = gfMul(p, p); // Runs through b^2 up to b^128
			r = gfMul(r, p);
		end
		return r;
	endfunction

	function automatic logic [7:0] rotl8(input logic [7:0] b, input int n);
		logic [7:0] r;
		for (int i = 0; i < 8; i++)
		begin
			r[(i + n) % 8] = b[i];
		end
		return r;
	endfunction

	// ####################
	// Substitution boxes

	function automatic logic [7:0] sbox(input logic [7:0] b);
		logic [7:0] inv;
		inv = gfInv(b);
		return inv ^ rotl8(inv, 1) ^ rotl8(inv, 2) ^ rotl8(inv, 3) ^ rotl8(inv, 4) ^ 8'h63;
	endfunction

	function automatic logic [7:0] invSbox(input logic [7:0] b);
		logic [7:0] pre;
		pre = rotl8(b, 1) ^ rotl8(b, 3) ^ rotl8(b, 6) ^ 8'h05; // Undo the affine map first
		return gfInv(pre);
	endfunction

endpackage

/* aesCtrlPkg.sv */
`include "aesDecrypt_cfg.svh"

package aesCtrlPkg;

	typedef enum logic [2:0] {
		seqIdle,
		seqExpand,
		seqAddKey,
		seqInvShift,
		seqInvSub,
		seqInvMix,
		seqDone
	} seqStateE;

	typedef enum logic [1:0] {
		opAddKey,
		opInvShift,
		opInvSub,
		opInvMix
	} roundOpE;

	// Per-cycle command to the datapath and the round key read port
	typedef struct packed {
		roundOpE op;
		logic opEn;
		logic [`AES_ROUND_W-1:0] round;
	} roundCtrlS;

endpackage

/* invMixColumns.sv */
`timescale 1ns/10ps

module invMixColumns (
	input aesTypesPkg::aesStateU stateIn,
	output aesTypesPkg::aesStateU stateOut
);

	// Rows 0..3 of every column against rows of {0e 0b 0d 09} rotated
	always_comb
	begin
		logic [7:0] a [4];
		logic [7:0] m09 [4];
		logic [7:0] m0b [4];
		logic [7:0] m0d [4];
		logic [7:0] m0e [4];
		logic [7:0] x2;
		logic [7:0] x4;
		logic [7:0] x8;
		for (int c = 0; c < 4; c++)
		begin
			for (int r = 0; r < 4; r++)
			begin
				a[r] = stateIn.bytes[4*c + r];
				x2 = aesTypesPkg::xtime(a[r]);
				x4 = aesTypesPkg::xtime(x2);
				x8 = aesTypesPkg::xtime(x4);
				m09[r] = x8 ^ a[r];
				m0b[r] = x8 ^ x2 ^ a[r];
				m0d[r] = x8 ^ x4 ^ a[r];
				m0e[r] = x8 ^ x4 ^ x2;
			end
			stateOut.bytes[4*c] = m0e[0] ^ m0b[1] ^ m0d[2] ^ m09[3];
			stateOut.bytes[4*c + 1] = m09[0] ^ m0e[1] ^ m0b[2] ^ m0d[3];
			stateOut.bytes[4*c + 2] = m0d[0] ^ m09[1] ^ m0e[2] ^ m0b[3];
			stateOut.bytes[4*c + 3] = m0b[0] ^ m0d[1] ^ m09[2] ^ m0e[3];
		end
	end

endmodule

/* keySchedule.sv */
`timescale 1ns/10ps
`include "aesDecrypt_cfg.svh"

module keySchedule (
	input logic Clk,
	input logic arstN,
	input logic keyExpand,
	input aesTypesPkg::aesBlockT cipherKey,
	input aesCtrlPkg::roundCtrlS roundCtrl,
	output logic keyReady,
	output aesTypesPkg::aesBlockT roundKey
);

	aesTypesPkg::aesBlockT keyStore [`AES_NUM_ROUND_KEYS];
	aesTypesPkg::aesBlockT workKey; // Most recent round key
	aesTypesPkg::aesBlockT nextKey;
	logic [`AES_ROUND_W-1:0] keyIdx;
	logic busy;
	logic [7:0] rcon;

	// ####################
	// One expansion step

	always_comb
	begin
		aesTypesPkg::aesWordT w0;
		aesTypesPkg::aesWordT w1;
		aesTypesPkg::aesWordT w2;
		aesTypesPkg::aesWordT w3;
		aesTypesPkg::aesWordT rotWord;
		aesTypesPkg::aesWordT temp;
		w0 = workKey[127:96];
		w1 = workKey[95:64];
		w2 = workKey[63:32];
		w3 = workKey[31:0];
		rotWord = {w3[23:0], w3[31:24]};
		temp = {aesTypesPkg::sbox(rotWord[31:24]) ^ rcon,
			aesTypesPkg::sbox(rotWord[23:16]),
			aesTypesPkg::sbox(rotWord[15:8]),
			aesTypesPkg::sbox(rotWord[7:0])};
		nextKey[127:96] = w0 ^ temp;
		nextKey[95:64] = w1 ^ nextKey[127:96];
		nextKey[63:32] = w2 ^ nextKey[95:64];
		nextKey[31:0] = w3 ^ nextKey[63:32];
	end

	// ####################
	// Control

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			busy <= 1'b0;
			keyIdx <= '0;
			keyReady <= 1'b0;
		end
		else if (keyExpand)
		begin
			busy <= 1'b1;
			keyIdx <= `AES_ROUND_W'(1);
			keyReady <= 1'b0;
		end
		else if (busy)
		begin
			keyIdx <= keyIdx + 1'b1;
			if (keyIdx == `AES_ROUND_W'(`AES_NUM_ROUNDS))
			begin
				busy <= 1'b0;
				keyReady <= 1'b1; // Last round key is written this cycle
			end
		end
	end

	always_ff @(posedge Clk)
	begin
		if (keyExpand)
		begin
			keyStore[0] <= cipherKey;
			workKey <= cipherKey;
			rcon <= 8'h01;
		end
		else if (busy)
		begin
			keyStore[keyIdx] <= nextKey;
			workKey <= nextKey;
			rcon <= aesTypesPkg::xtime(rcon);
		end
	end

	assign roundKey = keyStore[roundCtrl.round];

endmodule

/* invRoundDatapath.sv */
`timescale 1ns/10ps

module invRoundDatapath (
	input logic Clk,
	input logic arstN,
	input logic loadBlock,
	input aesTypesPkg::aesBlockT cipherText,
	input aesCtrlPkg::roundCtrlS roundCtrl,
	input aesTypesPkg::aesBlockT roundKey,
	output aesTypesPkg::aesBlockT plainText
);

	aesTypesPkg::aesStateU stateQ;
	aesTypesPkg::aesStateU keyState;
	aesTypesPkg::aesStateU shiftOut;
	aesTypesPkg::aesStateU subOut;
	aesTypesPkg::aesStateU addOut;
	aesTypesPkg::aesStateU mixOut;
	aesTypesPkg::aesStateU stateNext;

	assign keyState = roundKey;

	// ####################
	// Round operations

	// Row r moves r columns to the right
	always_comb
	begin
		for (int c = 0; c < 4; c++)
		begin
			for (int r = 0; r < 4; r++)
			begin
				shiftOut.bytes[4*c + r] = stateQ.bytes[4*((c + 4 - r) % 4) + r];
			end
		end
	end

	always_comb
	begin
		for (int i = 0; i < 16; i++)
		begin
			subOut.bytes[i] = aesTypesPkg::invSbox(stateQ.bytes[i]);
		end
	end

	always_comb
	begin
		for (int c = 0; c < 4; c++)
		begin
			addOut.cols[c] = stateQ.cols[c] ^ keyState.cols[c]; // Key words line up with columns
		end
	end

	invMixColumns invMixColumns_inst (
		.stateIn(stateQ),
		.stateOut(mixOut)
	);

	always_comb
	begin
		unique case (roundCtrl.op)
			aesCtrlPkg::opAddKey:
				stateNext = addOut;
			aesCtrlPkg::opInvShift:
				stateNext = shiftOut;
			aesCtrlPkg::opInvSub:
				stateNext = subOut;
			aesCtrlPkg::opInvMix:
				stateNext = mixOut;
			default:
				stateNext = stateQ;
		endcase
	end

	// ####################
	// State register

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
			stateQ <= '0;
		else if (loadBlock)
			stateQ <= cipherText;
		else if (roundCtrl.opEn)
			stateQ <= stateNext;
	end

	assign plainText = stateQ; // Holds the result once the sequencer reaches done

endmodule

/* invCipherSequencer.sv */
`timescale 1ns/10ps
`include "aesDecrypt_cfg.svh"

module invCipherSequencer (
	input logic Clk,
	input logic arstN,
	input logic start,
	input logic keyReady,
	output logic keyExpand,
	output logic loadBlock,
	output aesCtrlPkg::roundCtrlS roundCtrl,
	output logic done
);

	aesCtrlPkg::seqStateE stateQ;
	aesCtrlPkg::seqStateE stateNext;
	logic [`AES_ROUND_W-1:0] roundQ;
	logic leaveIdle;

	assign leaveIdle = (stateQ == aesCtrlPkg::seqIdle) && start;
	assign keyExpand = leaveIdle;
	assign loadBlock = leaveIdle; // Block and key are taken in the same cycle
	assign done = (stateQ == aesCtrlPkg::seqDone);

	// ####################
	// State and round registers

	always_ff @(posedge Clk or negedge arstN)
	begin
		if (!arstN)
		begin
			stateQ <= aesCtrlPkg::seqIdle;
			roundQ <= `AES_ROUND_W'(`AES_NUM_ROUNDS);
		end
		else
		begin
			stateQ <= stateNext;
			if (leaveIdle)
				roundQ <= `AES_ROUND_W'(`AES_NUM_ROUNDS);
			else if (stateQ == aesCtrlPkg::seqAddKey && roundQ != '0)
				roundQ <= roundQ - 1'b1; // Next key is one round lower
		end
	end

	always_comb
	begin
		stateNext = stateQ;
		unique case (stateQ)
			aesCtrlPkg::seqIdle:
				if (start)
					stateNext = aesCtrlPkg::seqExpand;
			aesCtrlPkg::seqExpand:
				if (keyReady)
					stateNext = aesCtrlPkg::seqAddKey;
			aesCtrlPkg::seqAddKey:
				if (roundQ == '0)
					stateNext = aesCtrlPkg::seqDone;
				else if (roundQ == `AES_ROUND_W'(`AES_NUM_ROUNDS))
					stateNext = aesCtrlPkg::seqInvShift; // No InvMixColumns after the first key
				else
					stateNext = aesCtrlPkg::seqInvMix;
			aesCtrlPkg::seqInvMix:
				stateNext = aesCtrlPkg::seqInvShift;
			aesCtrlPkg::seqInvShift:
				stateNext = aesCtrlPkg::seqInvSub;
			aesCtrlPkg::seqInvSub:
				stateNext = aesCtrlPkg::seqAddKey;
			aesCtrlPkg::seqDone:
				if (!start)
					stateNext = aesCtrlPkg::seqIdle; // Wait here for the host to release start
			default:
				stateNext = aesCtrlPkg::seqIdle;
		endcase
	end

	// ####################
	// Round control

	always_comb
	begin
		roundCtrl.round = roundQ;
		roundCtrl.opEn = 1'b1;
		unique case (stateQ)
			aesCtrlPkg::seqAddKey:
				roundCtrl.op = aesCtrlPkg::opAddKey;
			aesCtrlPkg::seqInvShift:
				roundCtrl.op = aesCtrlPkg::opInvShift;
			aesCtrlPkg::seqInvSub:
				roundCtrl.op = aesCtrlPkg::opInvSub;
			aesCtrlPkg::seqInvMix:
				roundCtrl.op = aesCtrlPkg::opInvMix;
			default:
			begin
				roundCtrl.op = aesCtrlPkg::opAddKey;
				roundCtrl.opEn = 1'b0; // Idle, expand and done leave the state alone
			end
		endcase
	end

endmodule

/* aesDecryptTop.sv */
`timescale 1ns/10ps

module aesDecryptTop (
	input logic Clk,
	input logic arstN,
	input logic start,
	input aesTypesPkg::aesBlockT cipherKey,
	input aesTypesPkg::aesBlockT cipherText,
	output aesTypesPkg::aesBlockT plainText,
	output logic done
);

	logic keyExpand;
	logic loadBlock;
	logic keyReady;
	aesCtrlPkg::roundCtrlS roundCtrl;
	aesTypesPkg::aesBlockT roundKey;

	invCipherSequencer invCipherSequencer_inst (
		.Clk(Clk),
		.arstN(arstN),
		.start(start),
		.keyReady(keyReady),
		.keyExpand(keyExpand),
		.loadBlock(loadBlock),
		.roundCtrl(roundCtrl),
		.done(done)
	);

	keySchedule keySchedule_inst (
		.Clk(Clk),
		.arstN(arstN),
		.keyExpand(keyExpand),
		.cipherKey(cipherKey),
		.roundCtrl(roundCtrl),
		.keyReady(keyReady),
		.roundKey(roundKey)
	);

	invRoundDatapath invRoundDatapath_inst (
		.Clk(Clk),
		.arstN(arstN),
		.loadBlock(loadBlock),
		.cipherText(cipherText),
		.roundCtrl(roundCtrl),
		.roundKey(roundKey),
		.plainText(plainText)
	);

endmodule

/* tb_aesDecrypt.sv */
`timescale 1ns/10ps

module tb_aesDecrypt;

	localparam int ClkPeriod = 100;
	localparam int Latency = 51; // Sampling edge of start to done
	localparam int DoneLimit = 100;
	localparam int CyclesPerVector = 80;
	localparam int AbortIndex = 3;

	logic Clk;
	logic arstN;
	logic start;
	aesTypesPkg::aesBlockT cipherKey;
	aesTypesPkg::aesBlockT cipherText;
	aesTypesPkg::aesBlockT plainText;
	logic done;

	aesTypesPkg::aesBlockT keyQ [$];
	aesTypesPkg::aesBlockT cipherQ [$];
	aesTypesPkg::aesBlockT plainQ [$];
	int vecCount;
	int errorCount;
	int checkCount;
	logic vectorsLoaded;
	logic [15:0] lfsrState;

	aesDecryptTop aesDecryptTop_inst (
		.Clk(Clk),
		.arstN(arstN),
		.start(start),
		.cipherKey(cipherKey),
		.cipherText(cipherText),
		.plainText(plainText),
		.done(done)
	);

	always #(ClkPeriod / 2) Clk = ~Clk;

	// ####################
	// Helpers

	// Galois form, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic drawBits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			value = (value << 1) | {31'd0, lfsrState[0]}; // One step per bit
		end
	endtask

	task automatic checkEqual(input logic [127:0] actual, input logic [127:0] expected,
		input string what);
		checkCount++;
		if (actual !== expected)
		begin
			errorCount++;
			$display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual,
				expected);
		end
	endtask

	task automatic readVectors();
		int fd;
		int fields;
		string line;
		aesTypesPkg::aesBlockT k;
		aesTypesPkg::aesBlockT c;
		aesTypesPkg::aesBlockT p;
		fd = $fopen("aesDecrypt_golden.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the vector file aesDecrypt_golden.txt");
			errorCount++;
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 0 && line[0] != "#") // Lines starting with # describe the columns
			begin
				fields = $sscanf(line, "%h %h %h", k, c, p);
				if (fields == 3)
				begin
					keyQ.push_back(k);
					cipherQ.push_back(c);
					plainQ.push_back(p);
				end
			end
		end
		$fclose(fd);
		vecCount = keyQ.size();
	endtask

	// ####################
	// Host sequences

	task automatic runVector(input int idx);
		int gap;
		int hold;
		int cycles;
		aesTypesPkg::aesBlockT held;
		drawBits(3, gap);
		drawBits(2, hold);
		for (int i = 0; i < gap; i++)
		begin
			@(negedge Clk);
			checkEqual(128'(done), 128'(0), "done high during idle gap");
		end
		cipherKey = keyQ[idx];
		cipherText = cipherQ[idx];
		start = 1'b1;
		@(negedge Clk); // Edge 0 has taken start
		cycles = 0;
		while (done !== 1'b1 && cycles < DoneLimit)
		begin
			@(negedge Clk);
			cycles++;
		end
		if (done !== 1'b1)
		begin
			errorCount++;
			$display("done never rose for vector %0d", idx);
		end
		else
		begin
			checkEqual(128'(cycles), 128'(Latency), $sformatf("latency of vector %0d", idx));
			checkEqual(plainText, plainQ[idx], $sformatf("plaintext of vector %0d", idx));
		end
		held = plainText;
		for (int i = 0; i < hold; i++)
		begin
			@(negedge Clk);
			checkEqual(128'(done), 128'(1), "done fell while start was held");
			checkEqual(plainText, held, "plaintext changed while done was high");
		end
		start = 1'b0;
		@(negedge Clk);
		checkEqual(128'(done), 128'(0), "done still high a cycle after start fell");
	endtask

	// Starts a block and pulls reset in the middle of the inverse walk
	task automatic abortVector(input int idx);
		int extra;
		drawBits(3, extra);
		cipherKey = keyQ[idx];
		cipherText = cipherQ[idx];
		start = 1'b1;
		repeat (20 + extra) @(negedge Clk);
		arstN = 1'b0;
		start = 1'b0;
		repeat (3)
		begin
			@(negedge Clk);
			checkEqual(128'(done), 128'(0), "done high during reset");
		end
		arstN = 1'b1;
		repeat (Latency - 20 - extra)
		begin
			@(negedge Clk);
			checkEqual(128'(done), 128'(0), "done rose for the aborted block"); // Window covers edge 51
		end
	endtask

	// ####################
	// Main sequence and watchdog

	initial
	begin
		Clk = 1'b0;
		arstN = 1'b0;
		start = 1'b0;
		cipherKey = '0;
		cipherText = '0;
		errorCount = 0;
		checkCount = 0;
		vecCount = 0;
		vectorsLoaded = 1'b0;
		lfsrState = 16'd24667;
		readVectors();
		if (vecCount == 0)
		begin
			errorCount++;
			$display("No test vectors were read");
		end
		vectorsLoaded = 1'b1;
		repeat (3) @(posedge Clk);
		@(negedge Clk);
		arstN = 1'b1;
		for (int i = 0; i < vecCount; i++)
		begin
			if (i == AbortIndex)
				abortVector(i);
			runVector(i);
		end
		@(negedge Clk);
		$display("Vectors: %0d, checks: %0d, errors: %0d", vecCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		wait (vectorsLoaded);
		#((vecCount + 2) * CyclesPerVector * ClkPeriod);
		$display("Simulation ran too long and was stopped by the watchdog");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* aesDecrypt_golden.txt */
# Columns: cipherKey cipherText expectedPlainText, each 128-bit hex, byte 0 first
# One block per line, decrypted in file order
000102030405060708090a0b0c0d0e0f 69c4e0d86a7b0430d8cdb78070b4c55a 00112233445566778899aabbccddeeff
2b7e151628aed2a6abf7158809cf4f3c 3925841d02dc09fbdc118597196a0b32 3243f6a8885a308d313198a2e0370734
00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e 00000000000000000000000000000000
2b7e151628aed2a6abf7158809cf4f3c 3ad77bb40d7a3660a89ecaf32466ef97 6bc1bee22e409f96e93d7e117393172a
2b7e151628aed2a6abf7158809cf4f3c f5d3d58503b9699de785895a96fdbaaf ae2d8a571e03ac9c9eb76fac45af8e51
2b7e151628aed2a6abf7158809cf4f3c 43b1cd7f598ece23881b00e3ed030688 30c81c46a35ce411e5fbc1191a0a52ef
2b7e151628aed2a6abf7158809cf4f3c 7b0c785e27e8ad3f8223207104725dd4 f69f2445df4f9b17ad2b417be66c3710

/* tb.f */
+incdir+.
aesTypesPkg.sv
aesCtrlPkg.sv
invMixColumns.sv
keySchedule.sv
invRoundDatapath.sv
invCipherSequencer.sv
aesDecryptTop.sv
tb_aesDecrypt.sv

/* Makefile */
SIM        = verilator
SIM_FLAGS  = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_aesDecrypt
RTL_TOP    = aesDecryptTop
FILELIST   = tb.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG) || (echo "Simulation did not finish"; exit 1)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
